/* nn_defs.svh */
`ifndef NN_DEFS_SVH
`define NN_DEFS_SVH

// layer size
`define N_IN 16
`define N_OUT 8

// activation table and word width
`define LUT_DEPTH 1024
`define FIX_W 32

// host word address map
`define WB_AW 12
`define REG_CTRL 12'h000
`define REG_STATUS 12'h001
`define FEAT_BASE 12'h040
`define BIAS_BASE 12'h080
`define OUT_BASE 12'h0C0
`define LUT_BASE 12'h400
// weight of input i, neuron n at i * N_OUT + n
`define WGT_BASE 12'h800

`endif

/* fixed_pkg.sv */
`include "nn_defs.svh"

package fixed_pkg;

	// Q16.16 signed value
	typedef logic signed [`FIX_W-1:0] fix_t;

	// full-width product before truncation
	typedef logic signed [2*`FIX_W-1:0] prod_t;

	// table index and fraction taken from the magnitude bits
	typedef logic [$clog2(`LUT_DEPTH)-1:0] lut_idx_t;
	typedef logic [7:0] frac_t;

	localparam fix_t FIX_ONE = 32'sh0001_0000;
	localparam fix_t FIX_HALF = 32'sh0000_8000;

endpackage

/* accel_pkg.sv */
package accel_pkg;

	// activation selected in the control register
	typedef enum logic [1:0] {
		ACT_TANH = 2'd0,
		ACT_SIGMOID = 2'd1,
		ACT_RELU = 2'd2
	} act_mode_e;

	// sequencer states
	typedef enum logic [2:0] {
		ENG_IDLE,
		ENG_BIAS,
		ENG_MAC,
		ENG_ISSUE,
		ENG_DRAIN
	} eng_state_e;

	// host target decoded from the word address
	typedef enum logic [2:0] {
		RGN_CTRL,
		RGN_STATUS,
		RGN_FEAT,
		RGN_BIAS,
		RGN_OUT,
		RGN_LUT,
		RGN_WGT,
		RGN_NONE
	} region_e;

endpackage

/* accel_ifs.sv */
`timescale 1ns/10ps
`include "nn_defs.svh"

// host access into the coefficient memories
interface host_mem_if import fixed_pkg::*, accel_pkg::*; ();
	logic wr_en;
	region_e rgn;
	// word offset inside the region
	logic [`WB_AW-1:0] addr;
	fix_t wdata;
	// valid one cycle after the request
	fix_t rdata;

	modport master (output wr_en, rgn, addr, wdata, input rdata);
	modport slave (input wr_en, rgn, addr, wdata, output rdata);
endinterface

// neuron sums handed to the activation pipeline
interface act_if import fixed_pkg::*, accel_pkg::*; ();
	logic op_valid;
	fix_t op_sum;
	act_mode_e op_mode;
	logic [$clog2(`N_OUT)-1:0] op_idx;
	// one pulse per retired neuron
	logic res_valid;

	modport source (output op_valid, op_sum, op_mode, op_idx, input res_valid);
	modport sink (input op_valid, op_sum, op_mode, op_idx, output res_valid);
endinterface

/* wb_slave.sv */
`timescale 1ns/10ps
`include "nn_defs.svh"

module wb_slave import fixed_pkg::*, accel_pkg::*; (
	input logic clk,
	input logic rst,
	input logic cyc_i,
	input logic stb_i,
	input logic we_i,
	input logic [`WB_AW-1:0] adr_i,
	input fix_t dat_i,
	output fix_t dat_o,
	output logic ack_o,
	host_mem_if.master mem,
	output logic start_o,
	output act_mode_e mode_o,
	input logic busy_i,
	input logic done_i
);

	region_e rgn;
	region_e rgn_q;
	logic [`WB_AW-1:0] base;
	logic req;
	logic ack_q;
	logic start_q;
	act_mode_e mode_q;

	// address decode into region and region base
	always_comb begin
		rgn = RGN_NONE;
		base = '0;
		if (adr_i == `REG_CTRL) begin
			rgn = RGN_CTRL;
		end else if (adr_i == `REG_STATUS) begin
			rgn = RGN_STATUS;
		end else if (adr_i >= `FEAT_BASE && adr_i < `FEAT_BASE + `N_IN) begin
			rgn = RGN_FEAT;
			base = `FEAT_BASE;
		end else if (adr_i >= `BIAS_BASE && adr_i < `BIAS_BASE + `N_OUT) begin
			rgn = RGN_BIAS;
			base = `BIAS_BASE;
		end else if (adr_i >= `OUT_BASE && adr_i < `OUT_BASE + `N_OUT) begin
			rgn = RGN_OUT;
			base = `OUT_BASE;
		end else if (adr_i >= `LUT_BASE && adr_i < `LUT_BASE + `LUT_DEPTH) begin
			rgn = RGN_LUT;
			base = `LUT_BASE;
		end else if (adr_i >= `WGT_BASE && adr_i < `WGT_BASE + `N_IN * `N_OUT) begin
			rgn = RGN_WGT;
			base = `WGT_BASE;
		end
	end

	// first cycle of a request, ack follows one clock later
	assign req = cyc_i & stb_i & ~ack_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			ack_q <= 1'b0;
			rgn_q <= RGN_NONE;
			start_q <= 1'b0;
			mode_q <= ACT_TANH;
		end else begin
			ack_q <= req;
			if (req) begin
				rgn_q <= rgn;
			end
			// control writes are ignored during a run
			start_q <= 1'b0;
			if (req && we_i && rgn == RGN_CTRL && !busy_i) begin
				start_q <= dat_i[0];
				mode_q <= act_mode_e'(dat_i[2:1]);
			end
		end
	end

	// memory writes during a run are acked and dropped
	assign mem.wr_en = req & we_i & ~busy_i;
	assign mem.rgn = rgn;
	assign mem.addr = adr_i - base;
	assign mem.wdata = dat_i;

	always_comb begin
		case (rgn_q)
			RGN_CTRL: dat_o = {{(`FIX_W-3){1'b0}}, mode_q, 1'b0};
			RGN_STATUS: dat_o = {{(`FIX_W-2){1'b0}}, done_i, busy_i};
			default: dat_o = mem.rdata;
		endcase
	end

	assign ack_o = ack_q;
	assign start_o = start_q;
	assign mode_o = mode_q;

	a_ack_in_cycle: assert property (@(posedge clk) disable iff (rst) ack_o |-> cyc_i);

endmodule

/* coef_store.sv */
`timescale 1ns/10ps
`include "nn_defs.svh"

module coef_store import fixed_pkg::*, accel_pkg::*; (
	input logic clk,
	host_mem_if.slave mem,
	input logic [$clog2(`N_IN)-1:0] feat_addr_i,
	output fix_t feat_o,
	input logic [$clog2(`N_OUT)-1:0] bias_addr_i,
	output fix_t bias_o,
	input logic [$clog2(`N_IN*`N_OUT)-1:0] wgt_addr_i,
	output fix_t wgt_o,
	input lut_idx_t lut_idx_i,
	output fix_t lut_lo_o,
	output fix_t lut_hi_o,
	input logic res_valid_i,
	input logic [$clog2(`N_OUT)-1:0] res_idx_i,
	input fix_t res_data_i
);

	localparam int IW = $clog2(`N_IN);
	localparam int NW = $clog2(`N_OUT);
	localparam int WW = $clog2(`N_IN * `N_OUT);
	localparam int LW = $bits(lut_idx_t);

	fix_t feat_mem [`N_IN];
	fix_t bias_mem [`N_OUT];
	fix_t wgt_mem [`N_IN * `N_OUT];
	fix_t lut_mem [`LUT_DEPTH];
	fix_t out_mem [`N_OUT];
	lut_idx_t lut_idx_hi;

	// host loads, the output region is written only by the datapath
	always_ff @(posedge clk) begin
		if (mem.wr_en) begin
			case (mem.rgn)
				RGN_FEAT: feat_mem[mem.addr[IW-1:0]] <= mem.wdata;
				RGN_BIAS: bias_mem[mem.addr[NW-1:0]] <= mem.wdata;
				RGN_LUT: lut_mem[mem.addr[LW-1:0]] <= mem.wdata;
				RGN_WGT: wgt_mem[mem.addr[WW-1:0]] <= mem.wdata;
				default: ;
			endcase
		end
		if (res_valid_i) begin
			out_mem[res_idx_i] <= res_data_i;
		end
	end

	// host read port, one cycle latency
	always_ff @(posedge clk) begin
		case (mem.rgn)
			RGN_FEAT: mem.rdata <= feat_mem[mem.addr[IW-1:0]];
			RGN_BIAS: mem.rdata <= bias_mem[mem.addr[NW-1:0]];
			RGN_OUT: mem.rdata <= out_mem[mem.addr[NW-1:0]];
			RGN_LUT: mem.rdata <= lut_mem[mem.addr[LW-1:0]];
			RGN_WGT: mem.rdata <= wgt_mem[mem.addr[WW-1:0]];
			default: mem.rdata <= '0;
		endcase
	end

	// engine read ports
	always_ff @(posedge clk) begin
		feat_o <= feat_mem[feat_addr_i];
		bias_o <= bias_mem[bias_addr_i];
		wgt_o <= wgt_mem[wgt_addr_i];
	end

	// upper neighbour sticks at the last entry
	assign lut_idx_hi = (lut_idx_i == lut_idx_t'(`LUT_DEPTH - 1)) ? lut_idx_i : lut_idx_i + 1'b1;
	assign lut_lo_o = lut_mem[lut_idx_i];
	assign lut_hi_o = lut_mem[lut_idx_hi];

endmodule

/* dense_engine.sv */
`timescale 1ns/10ps
`include "nn_defs.svh"

module dense_engine import fixed_pkg::*, accel_pkg::*; (
	input logic clk,
	input logic rst,
	input logic start_i,
	input act_mode_e mode_i,
	output logic [$clog2(`N_IN)-1:0] feat_addr_o,
	input fix_t feat_i,
	output logic [$clog2(`N_OUT)-1:0] bias_addr_o,
	input fix_t bias_i,
	output logic [$clog2(`N_IN*`N_OUT)-1:0] wgt_addr_o,
	input fix_t wgt_i,
	act_if.source act,
	output logic busy_o,
	output logic done_o
);

	localparam int IW = $clog2(`N_IN);
	localparam int NW = $clog2(`N_OUT);
	localparam int WW = $clog2(`N_IN * `N_OUT);

	eng_state_e state;
	logic [NW-1:0] n_cnt;
	// input address counter, one ahead of the data in ENG_MAC
	logic [IW:0] i_cnt;
	logic [NW:0] ret_cnt;
	logic done_q;
	fix_t acc;
	prod_t prod;
	fix_t term;

	// read addresses follow the counters, data returns next cycle
	assign feat_addr_o = i_cnt[IW-1:0];
	assign bias_addr_o = n_cnt;
	assign wgt_addr_o = WW'(i_cnt[IW-1:0]) * WW'(`N_OUT) + WW'(n_cnt);

	// product keeps bits 47..16
	assign prod = prod_t'(feat_i) * prod_t'(wgt_i);
	assign term = fix_t'(prod[47:16]);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ENG_IDLE;
			n_cnt <= '0;
			i_cnt <= '0;
			ret_cnt <= '0;
			done_q <= 1'b0;
		end else begin
			if (act.res_valid) begin
				ret_cnt <= ret_cnt + 1'b1;
			end
			case (state)
				ENG_IDLE: begin
					if (start_i) begin
						state <= ENG_BIAS;
						n_cnt <= '0;
						i_cnt <= '0;
						ret_cnt <= '0;
						done_q <= 1'b0;
					end
				end
				ENG_BIAS: begin
					i_cnt <= 1;
					state <= ENG_MAC;
				end
				ENG_MAC: begin
					i_cnt <= i_cnt + 1'b1;
					if (i_cnt == (IW+1)'(`N_IN)) begin
						state <= ENG_ISSUE;
					end
				end
				ENG_ISSUE: begin
					i_cnt <= '0;
					if (n_cnt == NW'(`N_OUT - 1)) begin
						state <= ENG_DRAIN;
					end else begin
						n_cnt <= n_cnt + 1'b1;
						state <= ENG_BIAS;
					end
				end
				ENG_DRAIN: begin
					// wait for the pipeline to retire every neuron
					if (ret_cnt == (NW+1)'(`N_OUT)) begin
						state <= ENG_IDLE;
						done_q <= 1'b1;
					end
				end
				default: state <= ENG_IDLE;
			endcase
		end
	end

	// accumulator starts from the bias on the first product
	always_ff @(posedge clk) begin
		if (state == ENG_MAC) begin
			acc <= ((i_cnt == 1) ? bias_i : acc) + term;
		end
	end

	assign act.op_valid = (state == ENG_ISSUE);
	assign act.op_sum = acc;
	assign act.op_mode = mode_i;
	assign act.op_idx = n_cnt;

	assign busy_o = (state != ENG_IDLE);
	assign done_o = done_q;

	a_start_idle: assert property (@(posedge clk) disable iff (rst)
		start_i |-> !(state != ENG_IDLE && busy_o));

endmodule

/* activation_unit.sv */
`timescale 1ns/10ps
`include "nn_defs.svh"

module activation_unit import fixed_pkg::*, accel_pkg::*; (
	input logic clk,
	input logic rst,
	act_if.sink act,
	output lut_idx_t lut_idx_o,
	input fix_t lut_lo_i,
	input fix_t lut_hi_i,
	output logic res_valid_o,
	output logic [$clog2(`N_OUT)-1:0] res_idx_o,
	output fix_t res_data_o
);

	localparam int NW = $clog2(`N_OUT);
	localparam int FW = $bits(frac_t);
	// magnitudes at or past the table end saturate
	localparam logic [`FIX_W-1:0] SAT_LIM = `LUT_DEPTH << FW;

	fix_t pre;
	fix_t v;
	logic s1_valid, s2_valid;
	act_mode_e s1_mode, s2_mode;
	logic [NW-1:0] s1_idx, s2_idx;
	logic s1_neg, s2_neg;
	logic [`FIX_W-1:0] s1_abs;
	fix_t s1_pre, s2_pre;
	fix_t s2_mag;
	frac_t frac;
	logic [FW:0] w_lo;
	logic sat;
	prod_t interp;
	fix_t signed_mag;
	fix_t res_n;

	// stage 1: weight scale, sigmoid halving, magnitude
	assign pre = act.op_sum >>> 8;
	assign v = (act.op_mode == ACT_SIGMOID) ? (pre >>> 1) : pre;

	always_ff @(posedge clk) begin
		s1_mode <= act.op_mode;
		s1_idx <= act.op_idx;
		s1_pre <= pre;
		s1_neg <= v[`FIX_W-1];
		s1_abs <= v[`FIX_W-1] ? -v : v;
	end

	// stage 2: interpolate between entries i and i+1
	assign lut_idx_o = s1_abs[FW +: $bits(lut_idx_t)];
	assign frac = s1_abs[FW-1:0];
	assign w_lo = (FW+1)'(1 << FW) - frac;
	assign sat = (s1_abs >= SAT_LIM);
	assign interp = prod_t'(lut_lo_i) * prod_t'(w_lo) + prod_t'(lut_hi_i) * prod_t'(frac);

	always_ff @(posedge clk) begin
		s2_mode <= s1_mode;
		s2_idx <= s1_idx;
		s2_pre <= s1_pre;
		s2_neg <= s1_neg;
		s2_mag <= sat ? FIX_ONE : fix_t'(interp >>> FW);
	end

	// stage 3: sign back, then the selected form
	assign signed_mag = s2_neg ? -s2_mag : s2_mag;

	always_comb begin
		case (s2_mode)
			ACT_SIGMOID: res_n = (signed_mag >>> 1) + FIX_HALF;
			ACT_RELU: res_n = s2_pre[`FIX_W-1] ? '0 : s2_pre;
			default: res_n = signed_mag;
		endcase
	end

	always_ff @(posedge clk) begin
		res_idx_o <= s2_idx;
		res_data_o <= res_n;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			res_valid_o <= 1'b0;
		end else begin
			s1_valid <= act.op_valid;
			s2_valid <= s1_valid;
			res_valid_o <= s2_valid;
		end
	end

	assign act.res_valid = res_valid_o;

	// every valid operand must present a known table index
	a_lut_range: assert property (@(posedge clk) disable iff (rst)
		s1_valid |-> !$isunknown(lut_idx_o));

endmodule

/* dense_accel_top.sv */
`timescale 1ns/10ps
`include "nn_defs.svh"

module dense_accel_top import fixed_pkg::*, accel_pkg::*; (
	input logic clk,
	input logic rst,
	input logic wb_cyc_i,
	input logic wb_stb_i,
	input logic wb_we_i,
	input logic [`WB_AW-1:0] wb_adr_i,
	input logic [`FIX_W-1:0] wb_dat_i,
	// full-word access only, byte selects are not decoded
	input logic [`FIX_W/8-1:0] wb_sel_i,
	output logic [`FIX_W-1:0] wb_dat_o,
	output logic wb_ack_o
);

	logic start, busy, done;
	act_mode_e mode;
	logic [$clog2(`N_IN)-1:0] feat_addr;
	logic [$clog2(`N_OUT)-1:0] bias_addr;
	logic [$clog2(`N_IN*`N_OUT)-1:0] wgt_addr;
	fix_t feat, bias, wgt;
	lut_idx_t lut_idx;
	fix_t lut_lo, lut_hi;
	logic res_valid;
	logic [$clog2(`N_OUT)-1:0] res_idx;
	fix_t res_data;

	host_mem_if host_mem_if_inst ();
	act_if act_if_inst ();

	wb_slave wb_slave_inst (
		.clk(clk), .rst(rst), .cyc_i(wb_cyc_i), .stb_i(wb_stb_i), .we_i(wb_we_i),
		.adr_i(wb_adr_i), .dat_i(wb_dat_i), .dat_o(wb_dat_o), .ack_o(wb_ack_o),
		.mem(host_mem_if_inst.master), .start_o(start), .mode_o(mode),
		.busy_i(busy), .done_i(done)
	);

	coef_store coef_store_inst (
		.clk(clk), .mem(host_mem_if_inst.slave),
		.feat_addr_i(feat_addr), .feat_o(feat), .bias_addr_i(bias_addr), .bias_o(bias),
		.wgt_addr_i(wgt_addr), .wgt_o(wgt),
		.lut_idx_i(lut_idx), .lut_lo_o(lut_lo), .lut_hi_o(lut_hi),
		.res_valid_i(res_valid), .res_idx_i(res_idx), .res_data_i(res_data)
	);

	dense_engine dense_engine_inst (
		.clk(clk), .rst(rst), .start_i(start), .mode_i(mode),
		.feat_addr_o(feat_addr), .feat_i(feat), .bias_addr_o(bias_addr), .bias_i(bias),
		.wgt_addr_o(wgt_addr), .wgt_i(wgt),
		.act(act_if_inst.source), .busy_o(busy), .done_o(done)
	);

	activation_unit activation_unit_inst (
		.clk(clk), .rst(rst), .act(act_if_inst.sink),
		.lut_idx_o(lut_idx), .lut_lo_i(lut_lo), .lut_hi_i(lut_hi),
		.res_valid_o(res_valid), .res_idx_o(res_idx), .res_data_o(res_data)
	);

endmodule

/* tb_dense_accel.sv */
`timescale 1ns/10ps
`include "nn_defs.svh"

module tb_dense_accel import fixed_pkg::*, accel_pkg::*; ();

	typedef logic [`WB_AW-1:0] adr_t;
	typedef struct packed {
		act_mode_e mode;
		fix_t wmask;
		fix_t boff;
	} row_t;

	localparam int N_ROWS = 5;

	logic clk, rst;
	logic cyc, stb, we, ack;
	adr_t adr;
	fix_t dat_w, dat_r;
	logic [`FIX_W/8-1:0] sel;

	row_t rows [N_ROWS];
	fix_t feat_v [`N_IN];
	fix_t bias_v [`N_OUT];
	fix_t wgt_v [`N_IN * `N_OUT];
	logic [31:0] rand_state = 32'd63781;
	int errors = 0;
	int checks = 0;

	dense_accel_top dense_accel_top_inst (
		.clk(clk), .rst(rst), .wb_cyc_i(cyc), .wb_stb_i(stb), .wb_we_i(we),
		.wb_adr_i(adr), .wb_dat_i(dat_w), .wb_sel_i(sel),
		.wb_dat_o(dat_r), .wb_ack_o(ack)
	);

	always #5 clk = ~clk;

	task automatic abort_run(string why);
		$display("timeout: %s at %0t", why, $time);
		$display("checks %0d, errors %0d, timeouts 1", checks, errors);
		$display("TEST FAILED");
		$finish;
	endtask

	task automatic check_fix(fix_t got, fix_t exp, string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_status(fix_t word, logic exp_busy, logic exp_done, string what);
		checks++;
		if (word[0] !== exp_busy || word[1] !== exp_done) begin
			errors++;
			$display("MISMATCH at %0t: %s busy %b done %b, expected busy %b done %b",
				$time, what, word[0], word[1], exp_busy, exp_done);
		end
	endtask

	// one classic cycle, request held through the acking edge, then ack must drop
	task automatic bus_access(input adr_t a, input logic wr, input fix_t wd, output fix_t rd);
		int waited;
		@(negedge clk);
		cyc = 1'b1;
		stb = 1'b1;
		we = wr;
		adr = a;
		dat_w = wd;
		waited = 0;
		@(negedge clk);
		while (!ack) begin
			if (waited == 16) abort_run("no ack from the slave");
			@(negedge clk);
			waited++;
		end
		rd = dat_r;
		// cycle ends on the next rising edge with the request still up
		@(negedge clk);
		if (ack) begin
			errors++;
			$display("second ack for one access at %0t", $time);
		end
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
	endtask

	task automatic wb_write(adr_t a, fix_t d);
		fix_t unused;
		bus_access(a, 1'b1, d, unused);
	endtask

	task automatic wb_read(adr_t a, output fix_t d);
		bus_access(a, 1'b0, '0, d);
	endtask

	function automatic logic [31:0] next_rand();
		rand_state = rand_state * 32'd1103515245 + 32'd12345;
		return rand_state;
	endfunction

	// small signed value, magnitude limited by mask
	function automatic fix_t rand_fix(fix_t mask);
		logic [31:0] r;
		fix_t m;
		r = next_rand();
		m = fix_t'(r >> 7) & mask;
		return r[31] ? -m : m;
	endfunction

	function automatic fix_t lut_entry(int k);
		return fix_t'(k * 64);
	endfunction

	// interpolated table lookup, saturating at 4.0
	function automatic fix_t table_fn(fix_t v);
		fix_t a, mag;
		int i, i1, f;
		prod_t m;
		a = v[31] ? -v : v;
		if (a >= 32'sh0004_0000) begin
			mag = FIX_ONE;
		end else begin
			i = int'(a[17:8]);
			f = int'(a[7:0]);
			i1 = (i == `LUT_DEPTH - 1) ? i : i + 1;
			m = prod_t'(lut_entry(i)) * prod_t'(256 - f) + prod_t'(lut_entry(i1)) * prod_t'(f);
			mag = fix_t'(m >>> 8);
		end
		return v[31] ? -mag : mag;
	endfunction

	function automatic fix_t model_neuron(act_mode_e mode, int n);
		fix_t s, pre;
		prod_t p;
		s = bias_v[n];
		for (int i = 0; i < `N_IN; i++) begin
			p = prod_t'(wgt_v[i * `N_OUT + n]) * prod_t'(feat_v[i]);
			s = s + fix_t'(p >>> 16);
		end
		pre = s >>> 8;
		case (mode)
			ACT_SIGMOID: return (table_fn(pre >>> 1) >>> 1) + FIX_HALF;
			ACT_RELU: return pre[31] ? fix_t'(0) : pre;
			default: return table_fn(pre);
		endcase
	endfunction

	task automatic load_row(row_t row);
		for (int i = 0; i < `N_IN; i++) begin
			feat_v[i] = rand_fix(32'h0001_FFFF);
			wb_write(adr_t'(`FEAT_BASE + i), feat_v[i]);
		end
		for (int n = 0; n < `N_OUT; n++) begin
			// odd neurons get the offset with negative sign
			bias_v[n] = rand_fix(32'h0003_FFFF) + (n[0] ? -row.boff : row.boff);
			wb_write(adr_t'(`BIAS_BASE + n), bias_v[n]);
		end
		for (int k = 0; k < `N_IN * `N_OUT; k++) begin
			wgt_v[k] = rand_fix(row.wmask);
			wb_write(adr_t'(`WGT_BASE + k), wgt_v[k]);
		end
	endtask

	task automatic wait_done();
		fix_t w;
		int polls;
		polls = 0;
		w = '0;
		while (!w[1]) begin
			if (polls == 500) abort_run("done bit never set");
			wb_read(`REG_STATUS, w);
			polls++;
		end
		check_status(w, 1'b0, 1'b1, "status after run");
	endtask

	task automatic check_outputs(act_mode_e mode, int tag);
		fix_t w;
		for (int n = 0; n < `N_OUT; n++) begin
			wb_read(adr_t'(`OUT_BASE + n), w);
			check_fix(w, model_neuron(mode, n), $sformatf("row %0d output %0d", tag, n));
		end
	endtask

	initial begin
		fix_t w;
		clk = 1'b0;
		rst = 1'b1;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		dat_w = '0;
		sel = '1;
		// mode, weight mask, bias offset
		rows[0] = '{ACT_TANH, 32'h001F_FFFF, 32'h0};
		rows[1] = '{ACT_SIGMOID, 32'h001F_FFFF, 32'h0};
		rows[2] = '{ACT_RELU, 32'h000F_FFFF, 32'h0};
		rows[3] = '{ACT_TANH, 32'h0000_FFFF, 32'h1000_0000};
		rows[4] = '{ACT_SIGMOID, 32'h0000_FFFF, 32'h1000_0000};
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		wb_read(`REG_STATUS, w);
		check_status(w, 1'b0, 1'b0, "status after reset");
		for (int k = 0; k < `LUT_DEPTH; k++) begin
			wb_write(adr_t'(`LUT_BASE + k), lut_entry(k));
		end

		for (int r = 0; r < N_ROWS; r++) begin
			load_row(rows[r]);
			wb_write(`REG_CTRL, fix_t'({rows[r].mode, 1'b1}));
			wait_done();
			check_outputs(rows[r].mode, r);
		end

		// feature write and restart during a run must both be dropped
		load_row(rows[0]);
		wb_write(`REG_CTRL, fix_t'({ACT_TANH, 1'b1}));
		wb_read(`REG_STATUS, w);
		check_status(w, 1'b1, 1'b0, "status during run");
		wb_write(adr_t'(`FEAT_BASE + 3), 32'sh0007_0000);
		wb_write(`REG_CTRL, fix_t'({ACT_RELU, 1'b1}));
		wait_done();
		check_outputs(ACT_TANH, N_ROWS);
		wb_read(adr_t'(`FEAT_BASE + 3), w);
		check_fix(w, feat_v[3], "feature written while busy");

		$display("checks %0d, errors %0d, timeouts 0", checks, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* build.f */
+incdir+.
fixed_pkg.sv
accel_pkg.sv
accel_ifs.sv
wb_slave.sv
coef_store.sv
dense_engine.sv
activation_unit.sv
dense_accel_top.sv
tb_dense_accel.sv
